//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Datapath widths
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int ALU_OP_W  = 4;

    // ******************************************************************
    // Major opcodes kept in this core
    // ******************************************************************
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;

    // Arithmetic funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;   // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL and SRA, split on bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Load and store funct3
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // funct7 patterns, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;

    // ALU operation selector
    localparam logic [ALU_OP_W-1:0] ALU_NOP  = 4'd0;   // Result forced to zero
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd10;

    // Memory stage operation
    localparam logic [1:0] MEM_NOP   = 2'b00;
    localparam logic [1:0] MEM_LOAD  = 2'b01;
    localparam logic [1:0] MEM_STORE = 2'b10;

    // Access size and sign
    localparam logic [2:0] SZ_WORD   = 3'b000;
    localparam logic [2:0] SZ_HALF_U = 3'b001;
    localparam logic [2:0] SZ_HALF_S = 3'b010;
    localparam logic [2:0] SZ_BYTE_U = 3'b011;
    localparam logic [2:0] SZ_BYTE_S = 3'b100;

    // ******************************************************************
    // One instruction word, three field layouts
    // ******************************************************************
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm;       // Sign bit at [11]
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } i;
        struct packed {
            logic [6:0]           imm_hi;    // imm[11:5]
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_lo;    // imm[4:0], sits where rd would be
            logic [6:0]           opcode;
        } s;
    } inst_u;

endpackage

`default_nettype wire

//--- design/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic [XLEN-1:0]     opa,
    input  logic [XLEN-1:0]     opb,
    output logic [XLEN-1:0]     result
);

    logic [4:0] shamt;
    logic       lt_s, lt_u;

    assign shamt = opb[4:0];                       // Upper bits ignored
    assign lt_s  = $signed(opa) < $signed(opb);
    assign lt_u  = opa < opb;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            ALU_SRA:  result = $unsigned($signed(opa) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result = opa ^ opb;
            ALU_OR:   result = opa | opb;
            ALU_AND:  result = opa & opb;
            default:  result = '0;                 // ALU_NOP and spare codes
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file import rv_pkg::*; (
    input  logic                 CK_REF,
    input  logic                 RST_N,
    input  logic [REG_IDX_W-1:0] rs1_idx,
    input  logic [REG_IDX_W-1:0] rs2_idx,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data,
    input  logic                 wb_en,
    input  logic [REG_IDX_W-1:0] wb_idx,
    input  logic [XLEN-1:0]      wb_data
);

    logic [XLEN-1:0] regs [2**REG_IDX_W];

    // Write port, x0 writes dropped
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            for (int k = 0; k < 2**REG_IDX_W; k++)
                regs[k] <= '0;
        end else if (wb_en && (wb_idx != '0)) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // Combinational reads, no write-through
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- design/rv_fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_decode import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                 CK_REF,
    input  logic                 RST_N,
    output logic [XLEN-1:0]      inst_addr,
    input  logic [XLEN-1:0]      inst_data,
    output logic [REG_IDX_W-1:0] rs1_idx,
    output logic [REG_IDX_W-1:0] rs2_idx,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    output logic [ALU_OP_W-1:0]  ex_alu_op,
    output logic [XLEN-1:0]      ex_opa,
    output logic [XLEN-1:0]      ex_opb,
    output logic [1:0]           ex_mem_op,
    output logic [2:0]           ex_size,
    output logic [XLEN-1:0]      ex_store_data,
    output logic [REG_IDX_W-1:0] ex_rd,
    output logic                 ex_wb_en
);

    inst_u                ir;                 // Instruction register
    logic [XLEN-1:0]      imm_i, imm_s;
    logic [ALU_OP_W-1:0]  d_alu_op;
    logic [XLEN-1:0]      d_opa, d_opb;
    logic [1:0]           d_mem_op;
    logic [2:0]           d_size;
    logic                 d_wb_en;
    logic                 legal;

    // Arithmetic op from funct3, alt picks SUB or SRA
    function automatic logic [ALU_OP_W-1:0] alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ******************************************************************
    // Fetch, one word per cycle with no stalls
    // ******************************************************************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            inst_addr <= RESET_PC;
            ir        <= '0;                      // All-zero word is a bubble
        end else begin
            inst_addr <= inst_addr + XLEN'(4);
            ir        <= inst_data;
        end
    end

    // Sign-extended immediates
    assign imm_i = {{(XLEN-12){ir.i.imm[11]}}, ir.i.imm};
    assign imm_s = {{(XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};

    assign rs1_idx = ir.r.rs1;
    assign rs2_idx = ir.r.rs2;                    // Unused by I-type, read anyway

    // ******************************************************************
    // Decode
    // ******************************************************************
    always_comb begin
        d_alu_op = ALU_NOP;
        d_opa    = '0;
        d_opb    = '0;
        d_mem_op = MEM_NOP;
        d_size   = SZ_WORD;
        d_wb_en  = 1'b0;
        legal    = 1'b1;
        case (ir.r.opcode)
            OPC_OP_IMM: begin
                d_opa    = rs1_data;
                d_opb    = imm_i;                 // Shifts only use imm[4:0]
                d_wb_en  = 1'b1;
                d_alu_op = alu_sel(ir.r.funct3, (ir.r.funct3 == F3_SR) && ir.r.funct7[5]);
                if (ir.r.funct3 == F3_SLL)
                    legal = (ir.r.funct7 == F7_BASE);
                else if (ir.r.funct3 == F3_SR)
                    legal = (ir.r.funct7 == F7_BASE) || (ir.r.funct7 == F7_ALT);
            end
            OPC_OP: begin
                d_opa    = rs1_data;
                d_opb    = rs2_data;
                d_wb_en  = 1'b1;
                d_alu_op = alu_sel(ir.r.funct3, ir.r.funct7[5]);
                // ALT form exists only for SUB and SRA
                legal = (ir.r.funct7 == F7_BASE) ||
                        ((ir.r.funct7 == F7_ALT) &&
                         ((ir.r.funct3 == F3_ADD) || (ir.r.funct3 == F3_SR)));
            end
            OPC_LOAD: begin
                d_opa    = rs1_data;
                d_opb    = imm_i;
                d_alu_op = ALU_ADD;               // Effective address
                d_mem_op = MEM_LOAD;
                d_wb_en  = 1'b1;
                case (ir.r.funct3)
                    F3_LB:   d_size = SZ_BYTE_S;
                    F3_LH:   d_size = SZ_HALF_S;
                    F3_LW:   d_size = SZ_WORD;
                    F3_LBU:  d_size = SZ_BYTE_U;
                    F3_LHU:  d_size = SZ_HALF_U;
                    default: legal  = 1'b0;
                endcase
            end
            OPC_STORE: begin
                d_opa    = rs1_data;
                d_opb    = imm_s;
                d_alu_op = ALU_ADD;
                d_mem_op = MEM_STORE;
                case (ir.r.funct3)
                    F3_SB:   d_size = SZ_BYTE_S;  // Store data gets sign-extended
                    F3_SH:   d_size = SZ_HALF_S;
                    F3_SW:   d_size = SZ_WORD;
                    default: legal  = 1'b0;
                endcase
            end
            default: legal = 1'b0;                // Bubble or unknown opcode
        endcase

        if (!legal) begin                         // Collapse to a bubble
            d_alu_op = ALU_NOP;
            d_opa    = '0;
            d_opb    = '0;
            d_mem_op = MEM_NOP;
            d_size   = SZ_WORD;
            d_wb_en  = 1'b0;
        end
    end

    // Decode to execute register
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            ex_alu_op     <= ALU_NOP;
            ex_opa        <= '0;
            ex_opb        <= '0;
            ex_mem_op     <= MEM_NOP;
            ex_size       <= SZ_WORD;
            ex_store_data <= '0;
            ex_rd         <= '0;
            ex_wb_en      <= 1'b0;
        end else begin
            ex_alu_op     <= d_alu_op;
            ex_opa        <= d_opa;
            ex_opb        <= d_opb;
            ex_mem_op     <= d_mem_op;
            ex_size       <= d_size;
            ex_store_data <= rs2_data;
            ex_rd         <= ir.r.rd;
            ex_wb_en      <= d_wb_en && (ir.r.rd != '0);   // x0 never written
        end
    end

endmodule

`default_nettype wire

//--- design/rv_exec_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_mem_wb import rv_pkg::*; #(
    parameter int MEM_ADDR_W = 16
) (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  logic [ALU_OP_W-1:0]   ex_alu_op,
    input  logic [XLEN-1:0]       ex_opa,
    input  logic [XLEN-1:0]       ex_opb,
    input  logic [1:0]            ex_mem_op,
    input  logic [2:0]            ex_size,
    input  logic [XLEN-1:0]       ex_store_data,
    input  logic [REG_IDX_W-1:0]  ex_rd,
    input  logic                  ex_wb_en,
    output logic                  mem_read_wrn,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic [XLEN-1:0]       mem_wdata,
    input  logic [XLEN-1:0]       mem_rdata,
    output logic                  wb_en,
    output logic [REG_IDX_W-1:0]  wb_idx,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]      alu_result;
    logic [XLEN-1:0]      st_data;                // Store data after SB/SH extension
    logic [XLEN-1:0]      ld_data;                // Load data after size extension
    logic [XLEN-1:0]      m_alu;
    logic [2:0]           m_size;
    logic [REG_IDX_W-1:0] m_rd;
    logic                 m_load, m_wb_en;

    rv_alu u_alu (
        .alu_op (ex_alu_op),
        .opa    (ex_opa),
        .opb    (ex_opb),
        .result (alu_result)
    );

    // SB and SH put the sign-extended low part on the bus
    always_comb begin
        case (ex_size)
            SZ_BYTE_S: st_data = {{(XLEN-8){ex_store_data[7]}}, ex_store_data[7:0]};
            SZ_HALF_S: st_data = {{(XLEN-16){ex_store_data[15]}}, ex_store_data[15:0]};
            default:   st_data = ex_store_data;
        endcase
    end

    // ******************************************************************
    // Execute to memory, drives the data port directly
    // ******************************************************************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            mem_read_wrn <= 1'b1;
            mem_addr     <= '0;
            mem_wdata    <= '0;
            m_load       <= 1'b0;
            m_wb_en      <= 1'b0;
        end else begin
            mem_read_wrn <= (ex_mem_op != MEM_STORE);   // Low for exactly one cycle
            mem_addr     <= (ex_mem_op == MEM_NOP) ? '0 : alu_result[MEM_ADDR_W-1:0];
            mem_wdata    <= (ex_mem_op == MEM_STORE) ? st_data : '0;
            m_load       <= (ex_mem_op == MEM_LOAD);
            m_wb_en      <= ex_wb_en;
        end
    end

    always_ff @(posedge CK_REF) begin
        m_alu  <= alu_result;
        m_size <= ex_size;
        m_rd   <= ex_rd;
    end

    // Load extension from the low bits of the returned word
    always_comb begin
        case (m_size)
            SZ_BYTE_S: ld_data = {{(XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
            SZ_BYTE_U: ld_data = {{(XLEN-8){1'b0}}, mem_rdata[7:0]};
            SZ_HALF_S: ld_data = {{(XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
            SZ_HALF_U: ld_data = {{(XLEN-16){1'b0}}, mem_rdata[15:0]};
            default:   ld_data = mem_rdata;
        endcase
    end

    // ******************************************************************
    // Memory to writeback, register file writes on the next edge
    // ******************************************************************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N)
            wb_en <= 1'b0;
        else
            wb_en <= m_wb_en;
    end

    always_ff @(posedge CK_REF) begin
        wb_idx  <= m_rd;
        wb_data <= m_load ? ld_data : m_alu;    // Memory or ALU path
    end

endmodule

`default_nettype wire

//--- design/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; #(
    parameter int               MEM_ADDR_W = 16,
    parameter logic [XLEN-1:0]  RESET_PC   = '0
) (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    output logic [XLEN-1:0]       inst_addr,
    input  logic [XLEN-1:0]       inst_data,    // Returned in the same cycle
    output logic                  mem_read_wrn,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic [XLEN-1:0]       mem_wdata,
    input  logic [XLEN-1:0]       mem_rdata
);

    // Register file read side
    logic [REG_IDX_W-1:0] rs1_idx, rs2_idx;
    logic [XLEN-1:0]      rs1_data, rs2_data;

    // Decode to execute
    logic [ALU_OP_W-1:0]  ex_alu_op;
    logic [XLEN-1:0]      ex_opa, ex_opb, ex_store_data;
    logic [1:0]           ex_mem_op;
    logic [2:0]           ex_size;
    logic [REG_IDX_W-1:0] ex_rd;
    logic                 ex_wb_en;

    // Writeback
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_idx;
    logic [XLEN-1:0]      wb_data;

    rv_fetch_decode #(.RESET_PC(RESET_PC)) u_fetch_decode (
        .CK_REF, .RST_N,
        .inst_addr, .inst_data,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .ex_alu_op, .ex_opa, .ex_opb, .ex_mem_op,
        .ex_size, .ex_store_data, .ex_rd, .ex_wb_en
    );

    rv_reg_file u_reg_file (
        .CK_REF, .RST_N,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .wb_en, .wb_idx, .wb_data
    );

    rv_exec_mem_wb #(.MEM_ADDR_W(MEM_ADDR_W)) u_exec_mem_wb (
        .CK_REF, .RST_N,
        .ex_alu_op, .ex_opa, .ex_opb, .ex_mem_op,
        .ex_size, .ex_store_data, .ex_rd, .ex_wb_en,
        .mem_read_wrn, .mem_addr, .mem_wdata, .mem_rdata,
        .wb_en, .wb_idx, .wb_data
    );

endmodule

`default_nettype wire

//--- verif/tb_rv_prog.svh
`ifndef TB_RV_PROG_SVH
`define TB_RV_PROG_SVH

// Instruction encoders for the RV32I field layouts
function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

task automatic put(input logic [31:0] word);
    rom[prog_len] = word;                      // Next table row
    prog_len++;
endtask

task automatic bubbles(input int n);
    for (int k = 0; k < n; k++)
        put('0);
endtask

// Store from rs2 to a fixed address off x0 and the word the bus should carry
task automatic store_chk(input string name, input logic [2:0] f3, input logic [4:0] rs2,
                         input logic [11:0] addr, input logic [XLEN-1:0] exp);
    exp_name.push_back(name);
    exp_addr.push_back(MEM_ADDR_W'(addr));
    exp_data.push_back(exp);
    exp_pc.push_back(XLEN'(prog_len * 4));     // Own address of the store
    put(s_word(f3, 5'd0, rs2, addr));
endtask

// ********************************************************************
// Program and expected stores with x1 = 100 and x2 = -5
// ********************************************************************
task automatic build_program(input logic [XLEN-1:0] w0, input logic [XLEN-1:0] w1);
    put(i_word(OPC_OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd100));
    put(i_word(OPC_OP_IMM, F3_ADD, 5'd2, 5'd0, 12'hFFB));
    bubbles(3);
    // OP-IMM group into x3..x11
    put(i_word(OPC_OP_IMM, F3_ADD,  5'd3,  5'd2, 12'd7));
    put(i_word(OPC_OP_IMM, F3_SLT,  5'd4,  5'd2, 12'd1));
    put(i_word(OPC_OP_IMM, F3_SLTU, 5'd5,  5'd2, 12'd1));
    put(i_word(OPC_OP_IMM, F3_XOR,  5'd6,  5'd1, 12'h00F));
    put(i_word(OPC_OP_IMM, F3_OR,   5'd7,  5'd1, 12'hF00));   // Negative immediate
    put(i_word(OPC_OP_IMM, F3_AND,  5'd8,  5'd2, 12'h0F0));
    put(i_word(OPC_OP_IMM, F3_SLL,  5'd9,  5'd1, 12'd4));
    put(i_word(OPC_OP_IMM, F3_SR,   5'd10, 5'd2, 12'd28));
    put(i_word(OPC_OP_IMM, F3_SR,   5'd11, 5'd2, 12'h401));   // SRAI by 1
    store_chk("ADDI",  F3_SW, 5'd3,  12'h200, 32'h0000_0002);
    store_chk("SLTI",  F3_SW, 5'd4,  12'h204, 32'h0000_0001);
    store_chk("SLTIU", F3_SW, 5'd5,  12'h208, 32'h0000_0000);
    store_chk("XORI",  F3_SW, 5'd6,  12'h20C, 32'h0000_006B);
    store_chk("ORI",   F3_SW, 5'd7,  12'h210, 32'hFFFF_FF64);
    store_chk("ANDI",  F3_SW, 5'd8,  12'h214, 32'h0000_00F0);
    store_chk("SLLI",  F3_SW, 5'd9,  12'h218, 32'h0000_0640);
    store_chk("SRLI",  F3_SW, 5'd10, 12'h21C, 32'h0000_000F);
    store_chk("SRAI",  F3_SW, 5'd11, 12'h220, 32'hFFFF_FFFD);
    // OP group into x3..x12 with shift amounts 27 from x2 and 4 from x1
    put(r_word(F7_BASE, F3_ADD,  5'd3,  5'd1, 5'd2));
    put(r_word(F7_ALT,  F3_ADD,  5'd4,  5'd1, 5'd2));
    put(r_word(F7_BASE, F3_SLL,  5'd5,  5'd1, 5'd2));
    put(r_word(F7_BASE, F3_SLT,  5'd6,  5'd2, 5'd1));
    put(r_word(F7_BASE, F3_SLTU, 5'd7,  5'd2, 5'd1));
    put(r_word(F7_BASE, F3_XOR,  5'd8,  5'd1, 5'd2));
    put(r_word(F7_BASE, F3_SR,   5'd9,  5'd2, 5'd1));
    put(r_word(F7_ALT,  F3_SR,   5'd10, 5'd2, 5'd1));
    put(r_word(F7_BASE, F3_OR,   5'd11, 5'd1, 5'd2));
    put(r_word(F7_BASE, F3_AND,  5'd12, 5'd1, 5'd2));
    store_chk("ADD",  F3_SW, 5'd3,  12'h240, 32'h0000_005F);
    store_chk("SUB",  F3_SW, 5'd4,  12'h244, 32'h0000_0069);
    store_chk("SLL",  F3_SW, 5'd5,  12'h248, 32'h2000_0000);
    store_chk("SLT",  F3_SW, 5'd6,  12'h24C, 32'h0000_0001);
    store_chk("SLTU", F3_SW, 5'd7,  12'h250, 32'h0000_0000);
    store_chk("XOR",  F3_SW, 5'd8,  12'h254, 32'hFFFF_FF9F);
    store_chk("SRL",  F3_SW, 5'd9,  12'h258, 32'h0FFF_FFFF);
    store_chk("SRA",  F3_SW, 5'd10, 12'h25C, 32'hFFFF_FFFF);
    store_chk("OR",   F3_SW, 5'd11, 12'h260, 32'hFFFF_FFFF);
    store_chk("AND",  F3_SW, 5'd12, 12'h264, 32'h0000_0060);
    // Loads of the preloaded words at 0x100 and 0x104
    put(i_word(OPC_LOAD, F3_LB,  5'd3, 5'd0, 12'h100));
    put(i_word(OPC_LOAD, F3_LH,  5'd4, 5'd0, 12'h100));
    put(i_word(OPC_LOAD, F3_LW,  5'd5, 5'd0, 12'h104));
    put(i_word(OPC_LOAD, F3_LBU, 5'd6, 5'd0, 12'h104));
    put(i_word(OPC_LOAD, F3_LHU, 5'd7, 5'd0, 12'h100));
    store_chk("LB",  F3_SW, 5'd3, 12'h280, {{24{w0[7]}}, w0[7:0]});
    store_chk("LH",  F3_SW, 5'd4, 12'h284, {{16{w0[15]}}, w0[15:0]});
    store_chk("LW",  F3_SW, 5'd5, 12'h288, w1);
    store_chk("LBU", F3_SW, 5'd6, 12'h28C, {24'h0, w1[7:0]});
    store_chk("LHU", F3_SW, 5'd7, 12'h290, {16'h0, w0[15:0]});
    // Narrow stores put the sign-extended low part on the bus
    store_chk("SB", F3_SB, 5'd9,  12'h2C0, 32'hFFFF_FFFF);      // x9 = 0x0FFFFFFF
    store_chk("SH", F3_SH, 5'd9,  12'h2C4, 32'hFFFF_FFFF);      // Low half 0xFFFF
    // x0 stays zero and illegal codes do nothing
    put(i_word(OPC_OP_IMM, F3_ADD, 5'd0, 5'd0, 12'd123));
    put(r_word(7'h01, F3_ADD, 5'd14, 5'd1, 5'd2));             // MUL is not kept
    put(i_word(OPC_LOAD, 3'b011, 5'd15, 5'd0, 12'h100));      // LD
    put(s_word(3'b011, 5'd0, 5'd1, 12'h2F0));                 // SD makes no bus cycle
    bubbles(3);
    store_chk("x0",      F3_SW, 5'd0,  12'h2C8, 32'h0);
    store_chk("ill_op",  F3_SW, 5'd14, 12'h2CC, 32'h0);
    store_chk("ill_ld",  F3_SW, 5'd15, 12'h2D0, 32'h0);
endtask

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*;;

    localparam int              MEM_ADDR_W = 16;
    localparam logic [XLEN-1:0] RESET_PC   = '0;

    logic                  CK_REF;
    logic                  RST_N;
    logic [XLEN-1:0]       inst_addr, inst_data;
    logic                  mem_read_wrn;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [XLEN-1:0]       mem_wdata, mem_rdata;

    // ROM and RAM models
    logic [31:0]           rom [0:255];
    int                    prog_len = 0;
    logic [XLEN-1:0]       ram [logic [MEM_ADDR_W-1:0]];

    // Expected stores in bus order
    string                 exp_name[$];
    logic [MEM_ADDR_W-1:0] exp_addr[$];
    logic [XLEN-1:0]       exp_data[$];
    logic [XLEN-1:0]       exp_pc[$];
    int                    seen = 0;
    int                    cycles = 0;
    int                    limit = 100000;     // Tightened once the program is built
    logic [XLEN-1:0]       pc_model = RESET_PC;   // Fetch address the core should show

    `include "tb_rv_prog.svh"

    rv_core_top #(.MEM_ADDR_W(MEM_ADDR_W), .RESET_PC(RESET_PC)) u_dut (
        .CK_REF, .RST_N,
        .inst_addr, .inst_data,
        .mem_read_wrn, .mem_addr, .mem_wdata, .mem_rdata
    );

    initial begin
        CK_REF = 1'b0;
        forever #10 CK_REF = ~CK_REF;          // 20 ns period
    end

    // Same-cycle instruction return and zero past the table end
    always_comb begin
        if (int'(inst_addr[31:2]) < prog_len)
            inst_data = rom[inst_addr[9:2]];
        else
            inst_data = '0;
    end

    // Unwritten words read back an address-derived pattern
    always_comb begin
        if (ram.exists(mem_addr))
            mem_rdata = ram[mem_addr];
        else
            mem_rdata = XLEN'({~mem_addr, mem_addr});
    end

    task automatic check_addr(input string name, input logic [MEM_ADDR_W-1:0] exp,
                              input logic [MEM_ADDR_W-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s addr: expected %h, actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    // ********************************************************************
    // Bus monitor sampled at the edge that ends each cycle
    // ********************************************************************
    always @(posedge CK_REF) begin
        if (RST_N) begin
            check_word("inst_addr", pc_model, inst_addr);
            pc_model = pc_model + 32'd4;        // One word per cycle
            if (!mem_read_wrn) begin
                if (seen >= exp_addr.size()) begin
                    $display("Unexpected store to %h with %h", mem_addr, mem_wdata);
                    $display("TB FAILED");
                    $fatal(1, "extra store");
                end
                check_addr(exp_name[seen], exp_addr[seen], mem_addr);
                check_word(exp_name[seen], exp_data[seen], mem_wdata);
                check_word({exp_name[seen], " pc"}, exp_pc[seen] + 32'd12, inst_addr);
                seen++;
                ram[mem_addr] = mem_wdata;      // Write ends the store cycle
            end
        end
    end

    // Watchdog
    always @(posedge CK_REF) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, seen, exp_addr.size());
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [XLEN-1:0] w0, w1;
        RST_N = 1'b0;
        void'($urandom(32'h1fe09013));          // One seed for the whole run
        w0 = $urandom();
        w1 = $urandom();
        ram[16'h100] = w0;
        ram[16'h104] = w1;
        ram[16'h108] = $urandom();
        for (int k = 0; k < 256; k++)
            rom[k] = '0;
        build_program(w0, w1);
        limit = 8 + prog_len + 16;

        repeat (8) @(posedge CK_REF);
        RST_N <= 1'b1;

        // Walk the table and wait for every expected store
        for (int k = 0; k < prog_len; k++)
            @(posedge CK_REF);
        while (seen < exp_addr.size())
            @(posedge CK_REF);
        repeat (4) @(posedge CK_REF);          // No store may follow the last one

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
design/rv_pkg.sv
design/rv_alu.sv
design/rv_reg_file.sv
design/rv_fetch_decode.sv
design/rv_exec_mem_wb.sv
design/rv_core_top.sv
verif/tb_rv_core.sv

//--- Makefile
TOP       ?= tb_rv_core
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: TOP LOG VERILATOR OBJ_DIR"

test:
	$(VERILATOR) --binary --timing -f tb.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
